//--- design/rv_pkg.sv
package rv_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int xlen     = 32;
    localparam int alu_op_w = 4;
    localparam int imm_w    = 3;
    localparam int wb_w     = 2;

    // First fetch address after reset.
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // --------------------
    // Opcodes
    // --------------------

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // --------------------
    // ALU operations
    // --------------------

    localparam logic [alu_op_w-1:0] alu_and    = 4'b0000;
    localparam logic [alu_op_w-1:0] alu_or     = 4'b0001;
    localparam logic [alu_op_w-1:0] alu_add    = 4'b0010;
    localparam logic [alu_op_w-1:0] alu_sub    = 4'b0011;
    localparam logic [alu_op_w-1:0] alu_sll    = 4'b0100;
    localparam logic [alu_op_w-1:0] alu_slt    = 4'b0101;
    localparam logic [alu_op_w-1:0] alu_sltu   = 4'b0110;
    localparam logic [alu_op_w-1:0] alu_xor    = 4'b0111;
    localparam logic [alu_op_w-1:0] alu_srl    = 4'b1000;
    localparam logic [alu_op_w-1:0] alu_pass_b = 4'b1001;
    localparam logic [alu_op_w-1:0] alu_sra    = 4'b1010;

    // --------------------
    // Immediate kinds
    // --------------------

    localparam logic [imm_w-1:0] imm_i = 3'd1;
    localparam logic [imm_w-1:0] imm_s = 3'd2;
    localparam logic [imm_w-1:0] imm_b = 3'd3;
    localparam logic [imm_w-1:0] imm_u = 3'd4;
    localparam logic [imm_w-1:0] imm_j = 3'd5;

    // --------------------
    // Writeback sources
    // --------------------

    localparam logic [wb_w-1:0] wb_mem = 2'b00;
    localparam logic [wb_w-1:0] wb_alu = 2'b01;
    localparam logic [wb_w-1:0] wb_pc4 = 2'b10;

endpackage

//--- design/instr_ctl.sv
module instr_ctl (
    input  logic [rv_pkg::xlen-1:0]     instruction,
    input  logic                        br_eq,
    input  logic                        br_lt,
    output logic                        a_sel,
    output logic                        b_sel,
    output logic [rv_pkg::alu_op_w-1:0] alu_sel,
    output logic                        mem_wr,
    output logic                        reg_wen,
    output logic [rv_pkg::imm_w-1:0]    imm_sel,
    output logic                        br_un,
    output logic                        pc_sel,
    output logic [rv_pkg::wb_w-1:0]     wb_sel
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b30;
    logic [alu_op_w-1:0] arith_op;
    logic       br_taken;

    assign opcode     = instruction[6:0];
    assign funct3     = instruction[14:12];
    assign funct7_b30 = instruction[30];

    // Unsigned compare for BLTU and BGEU.
    assign br_un = funct3[1];

    // Arithmetic operation shared by the register-immediate and register-register forms.
    // Bit 30 only selects SUB for register-register ADD.
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == op_reg && funct7_b30) begin
                    arith_op = alu_sub;
                end else begin
                    arith_op = alu_add;
                end
            end
            3'b001: arith_op = alu_sll;
            3'b010: arith_op = alu_slt;
            3'b011: arith_op = alu_sltu;
            3'b100: arith_op = alu_xor;
            3'b101: arith_op = funct7_b30 ? alu_sra : alu_srl;
            3'b110: arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_eq;
            3'b001:  br_taken = !br_eq;
            3'b100:  br_taken = br_lt;
            3'b101:  br_taken = !br_lt;
            3'b110:  br_taken = br_lt;
            3'b111:  br_taken = !br_lt;
            default: br_taken = 1'b0;
        endcase
    end

    // a_sel picks pc when high, b_sel picks the immediate when high.
    always_comb begin
        a_sel   = 1'b0;
        b_sel   = 1'b1;
        alu_sel = alu_add;
        mem_wr  = 1'b0;
        reg_wen = 1'b0;
        imm_sel = imm_i;
        pc_sel  = 1'b0;
        wb_sel  = wb_alu;
        case (opcode)
            op_lui: begin
                alu_sel = alu_pass_b;
                reg_wen = 1'b1;
                imm_sel = imm_u;
            end
            op_auipc: begin
                a_sel   = 1'b1;
                reg_wen = 1'b1;
                imm_sel = imm_u;
            end
            op_jal: begin
                a_sel   = 1'b1;
                reg_wen = 1'b1;
                imm_sel = imm_j;
                pc_sel  = 1'b1;
                wb_sel  = wb_pc4;
            end
            op_jalr: begin
                reg_wen = 1'b1;
                pc_sel  = 1'b1;
                wb_sel  = wb_pc4;
            end
            op_branch: begin
                // The ALU forms the target, the comparator decides.
                a_sel   = 1'b1;
                imm_sel = imm_b;
                pc_sel  = br_taken;
            end
            op_load: begin
                reg_wen = 1'b1;
                wb_sel  = wb_mem;
            end
            op_store: begin
                mem_wr  = 1'b1;
                imm_sel = imm_s;
            end
            op_imm: begin
                alu_sel = arith_op;
                reg_wen = 1'b1;
            end
            op_reg: begin
                b_sel   = 1'b0;
                alu_sel = arith_op;
                reg_wen = 1'b1;
            end
            default: begin
                // Unknown opcode: no write of any kind, pc just advances.
                reg_wen = 1'b0;
            end
        endcase
    end

endmodule

//--- design/imm_gen.sv
module imm_gen (
    input  logic [rv_pkg::xlen-1:0]  instruction,
    input  logic [rv_pkg::imm_w-1:0] imm_sel,
    output logic [rv_pkg::xlen-1:0]  imm
);

    import rv_pkg::*;

    logic       sign;
    logic [xlen-1:0] i_type;
    logic [xlen-1:0] s_type;
    logic [xlen-1:0] b_type;
    logic [xlen-1:0] u_type;
    logic [xlen-1:0] j_type;

    assign sign = instruction[31];

    assign i_type = {{21{sign}}, instruction[30:20]};
    assign s_type = {{21{sign}}, instruction[30:25], instruction[11:7]};

    // B and J immediates are in units of two bytes, so bit 0 is always zero.
    assign b_type = {{20{sign}}, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
    assign j_type = {{12{sign}}, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};

    assign u_type = {instruction[31:12], 12'h000};

    always_comb begin
        case (imm_sel)
            imm_i:   imm = i_type;
            imm_s:   imm = s_type;
            imm_b:   imm = b_type;
            imm_u:   imm = u_type;
            imm_j:   imm = j_type;
            default: imm = i_type;
        endcase
    end

endmodule

//--- design/reg_file.sv
module reg_file (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    wen,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2
);

    import rv_pkg::*;

    // Only x1 to x31 are storage, x0 is a constant.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Reads are combinational and see the old value during a write cycle.
    always_comb begin
        if (rs1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

//--- design/alu.sv
module alu (
    input  logic [rv_pkg::xlen-1:0]     a,
    input  logic [rv_pkg::xlen-1:0]     b,
    input  logic [rv_pkg::alu_op_w-1:0] op,
    output logic [rv_pkg::xlen-1:0]     result
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

//--- design/exec_path.sv
module exec_path (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rv_pkg::xlen-1:0]     instruction,
    input  logic [rv_pkg::xlen-1:0]     imm,
    input  logic                        a_sel,
    input  logic                        b_sel,
    input  logic [rv_pkg::alu_op_w-1:0] alu_sel,
    input  logic                        mem_wr,
    input  logic                        reg_wen,
    input  logic                        br_un,
    input  logic                        pc_sel,
    input  logic [rv_pkg::wb_w-1:0]     wb_sel,
    output logic                        br_eq,
    output logic                        br_lt,
    output logic [rv_pkg::xlen-1:0]     pc,
    output logic [rv_pkg::xlen-1:0]     mem_addr,
    output logic [rv_pkg::xlen-1:0]     mem_wdata,
    input  logic [rv_pkg::xlen-1:0]     mem_rdata,
    output logic                        mem_wr_out,
    output logic                        wb_en,
    output logic [4:0]                  wb_rd,
    output logic [rv_pkg::xlen-1:0]     wb_data
);

    import rv_pkg::*;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_plus4;

    // --------------------
    // Program counter
    // --------------------

    assign pc_plus4 = pc + 32'd4;

    // Jump and branch targets come from the ALU sum, JALR needs bit 0 cleared.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_sel) begin
            pc <= {alu_result[xlen-1:1], 1'b0};
        end else begin
            pc <= pc_plus4;
        end
    end

    // --------------------
    // Operands and ALU
    // --------------------

    reg_file u_reg_file (
        .clk    (clk),
        .rs1    (instruction[19:15]),
        .rs2    (instruction[24:20]),
        .rd     (wb_rd),
        .wen    (wb_en),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign op_a = a_sel ? pc : rs1_data;
    assign op_b = b_sel ? imm : rs2_data;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_sel),
        .result (alu_result)
    );

    // Branch comparator works on the register operands, not the ALU inputs.
    assign br_eq = rs1_data == rs2_data;
    assign br_lt = br_un ? (rs1_data < rs2_data) : ($signed(rs1_data) < $signed(rs2_data));

    // --------------------
    // Memory and writeback
    // --------------------

    assign mem_addr   = alu_result;
    assign mem_wdata  = rs2_data;
    assign mem_wr_out = mem_wr && !reset;

    assign wb_en = reg_wen && !reset;
    assign wb_rd = instruction[11:7];

    always_comb begin
        case (wb_sel)
            wb_mem:  wb_data = mem_rdata;
            wb_pc4:  wb_data = pc_plus4;
            wb_alu:  wb_data = alu_result;
            default: wb_data = alu_result;
        endcase
    end

endmodule

//--- design/rv_core.sv
module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::xlen-1:0] instruction,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    output logic                    mem_wr,
    output logic                    wb_en,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::xlen-1:0] wb_data
);

    import rv_pkg::*;

    logic                a_sel;
    logic                b_sel;
    logic [alu_op_w-1:0] alu_sel;
    logic                ctl_mem_wr;
    logic                reg_wen;
    logic [imm_w-1:0]    imm_sel;
    logic                br_un;
    logic                pc_sel;
    logic [wb_w-1:0]     wb_sel;
    logic                br_eq;
    logic                br_lt;
    logic [xlen-1:0]     imm;

    instr_ctl u_instr_ctl (
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .mem_wr      (ctl_mem_wr),
        .reg_wen     (reg_wen),
        .imm_sel     (imm_sel),
        .br_un       (br_un),
        .pc_sel      (pc_sel),
        .wb_sel      (wb_sel)
    );

    imm_gen u_imm_gen (
        .instruction (instruction),
        .imm_sel     (imm_sel),
        .imm         (imm)
    );

    exec_path u_exec_path (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .imm         (imm),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .mem_wr      (ctl_mem_wr),
        .reg_wen     (reg_wen),
        .br_un       (br_un),
        .pc_sel      (pc_sel),
        .wb_sel      (wb_sel),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_wr_out  (mem_wr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

//--- test/rv_core_properties.sv
module rv_core_properties (
    input logic                    clk,
    input logic                    reset,
    input logic [rv_pkg::xlen-1:0] pc,
    input logic [rv_pkg::xlen-1:0] instruction,
    input logic [rv_pkg::xlen-1:0] rs1_data,
    input logic                    wb_en,
    input logic [4:0]              wb_rd
);

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    int failure_count = 0;

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc %08h is not word aligned", pc);
            failure_count++;
        end

    pc_after_reset: assert property (@(posedge clk) reset |=> pc == reset_pc)
        else begin
            $error("pc %08h after a reset edge", pc);
            failure_count++;
        end

    // A write to x0 must not show up on a later read of x0.
    x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        (wb_en && wb_rd == 5'd0) |=> (instruction[19:15] != 5'd0 || rs1_data == '0))
        else begin
            $error("x0 reads %08h after a write to x0", rs1_data);
            failure_count++;
        end

endmodule

bind exec_path rv_core_properties u_properties (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .instruction (instruction),
    .rs1_data    (rs1_data),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd)
);

//--- test/rv_core_tb.sv
module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int prog_base    = 4;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_wr;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] stim [0:255];
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] last_pc;

    int cycle_budget;
    int prog_len;
    int write_count;
    int store_count;
    int write_base;
    int store_base;
    int wb_index     = 0;
    int store_index  = 0;
    int cycle_count  = 0;
    int reset_errors = 0;
    int wb_errors    = 0;
    int store_errors = 0;
    int halt_errors  = 0;
    bit stim_loaded  = 1'b0;
    bit load_failed  = 1'b0;
    bit halted       = 1'b0;
    bit pc_valid     = 1'b0;

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_wr      (mem_wr),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------
    // Memory models
    // --------------------

    assign instruction = imem[pc[7:2]];
    assign mem_rdata   = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (mem_wr) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int group_errors);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s expected %08h, actual %08h",
                     $time, name, expected, actual);
            group_errors++;
        end
    endtask

    task automatic load_stimulus();
        int i;
        $readmemh("test/program_stimulus.txt", stim);
        load_failed = $isunknown({stim[0], stim[1], stim[2], stim[3]});
        cycle_budget = stim[0];
        prog_len     = stim[1];
        write_count  = stim[2];
        store_count  = stim[3];
        write_base   = prog_base + prog_len;
        store_base   = write_base + 2 * write_count;
        if (prog_len > 64 || $isunknown(stim[store_base + 2 * store_count - 1])) begin
            load_failed = 1'b1;
        end
        for (i = 0; i < prog_len && !load_failed; i++) begin
            imem[i] = stim[prog_base + i];
        end
        stim_loaded = !load_failed;
    endtask

    task automatic apply_reset();
        repeat (reset_cycles) @(posedge clk);
        #1;
        check_value("pc", 32'h0000_0000, pc, reset_errors);
        check_value("mem_wr", 32'h0, mem_wr, reset_errors);
        check_value("wb_en", 32'h0, wb_en, reset_errors);
        reset = 1'b0;
        $display("reset check done: %0d errors", reset_errors);
    endtask

    // Retire port and store port describe the write of the coming rising edge.
    always @(negedge clk) begin
        if (!reset && !halted) begin
            if (wb_en) begin
                if (wb_index < write_count) begin
                    check_value("wb_rd", stim[write_base + 2 * wb_index], wb_rd, wb_errors);
                    check_value("wb_data", stim[write_base + 2 * wb_index + 1], wb_data,
                                wb_errors);
                end else begin
                    $display("Register write to x%0d at %0d ns was not expected", wb_rd, $time);
                    wb_errors++;
                end
                wb_index++;
            end
            if (mem_wr) begin
                if (store_index < store_count) begin
                    check_value("mem_addr", stim[store_base + 2 * store_index], mem_addr,
                                store_errors);
                    check_value("mem_wdata", stim[store_base + 2 * store_index + 1], mem_wdata,
                                store_errors);
                end else begin
                    $display("Store to %08h at %0d ns was not expected", mem_addr, $time);
                    store_errors++;
                end
                store_index++;
            end
            // A self-jump leaves pc where it was.
            if (pc_valid && pc == last_pc) begin
                halted = 1'b1;
            end
            last_pc  = pc;
            pc_valid = 1'b1;
            cycle_count++;
        end
    end

    task automatic check_end_state();
        $display("register trace done: %0d of %0d writes, %0d errors",
                 wb_index, write_count, wb_errors);
        $display("store trace done: %0d of %0d stores, %0d errors",
                 store_index, store_count, store_errors);
        if (wb_index != write_count) begin
            $display("The core retired %0d register writes, the trace lists %0d",
                     wb_index, write_count);
            halt_errors++;
        end
        if (store_index != store_count) begin
            $display("The core made %0d stores, the trace lists %0d", store_index, store_count);
            halt_errors++;
        end
        if (cycle_count > cycle_budget) begin
            $display("The program needed %0d cycles, more than its budget of %0d",
                     cycle_count, cycle_budget);
            halt_errors++;
        end
        $display("halt check done: %0d cycles, %0d errors", cycle_count, halt_errors);
    endtask

    task automatic report_results();
        int total;
        total = reset_errors + wb_errors + store_errors + halt_errors
              + u_dut.u_exec_path.u_properties.failure_count + int'(load_failed);
        $display("assertion check done: %0d failures",
                 u_dut.u_exec_path.u_properties.failure_count);
        $display("summary: %0d writes, %0d stores, %0d errors", wb_index, store_index, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        load_stimulus();
        if (load_failed) begin
            $display("The stimulus file test/program_stimulus.txt is missing or incomplete");
        end else begin
            apply_reset();
            wait (halted);
            check_end_state();
        end
        report_results();
    end

    // Watchdog allows twice the cycle budget.
    initial begin
        wait (stim_loaded);
        #(2 * cycle_budget * clk_period);
        $display("Watchdog expired: the program did not halt within %0d ns",
                 2 * cycle_budget * clk_period);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- test/program_stimulus.txt
// Header: cycle budget, program words, register writes, stores (all hex).
// Then program words from address 0, register writes as rd value, stores as address value.
00000040 00000032 0000001b 00000002
// Program: ALU and upper immediates, stores and loads, branches, jumps, x0 write, halt
123450b7 67808093 00001117 ffb00193 00300213 004182b3 40320333 0041a3b3
0041b433 0ff0c493 4011d513 01c1d593 00421613 0040e6b3 0060f733 04102023
00362223 04002783 00462803 00420463 00100f93 00418463 00100a13 00419463
00100f93 00421463 001a0a13 0041c463 00100f93 00324463 001a0a13 00325463
00100f93 0041d463 001a0a13 00326463 00100f93 0041e463 001a0a13 0041f463
00100f93 00327463 001a0a13 00800aef 00100f93 0bd00b67 00100f93 00500013
00406c33 00000063
// Register writes in retire order
01 12345000 01 12345678 02 00001008
03 fffffffb 04 00000003 05 fffffffe
06 00000008 07 00000001 08 00000000
09 12345687 0a fffffffd 0b 0000000f
0c 00000030 0d 1234567b 0e 00000008
0f 12345678 10 fffffffb 14 00000001
14 00000002 14 00000003 14 00000004
14 00000005 14 00000006 15 000000b0
16 000000b8 00 00000005 18 00000003
// Stores in order
00000040 12345678 00000034 fffffffb

//--- verilog.f
design/rv_pkg.sv
design/instr_ctl.sv
design/imm_gen.sv
design/reg_file.sv
design/alu.sv
design/exec_path.sv
design/rv_core.sv
test/rv_core_properties.sv
test/rv_core_tb.sv
